// ==== rename_pkg.sv ====
package rename_pkg;

  // machine sizing
  localparam int DISP_SIZE    = 2;
  localparam int ARCH_REGS    = 32;
  localparam int REG_W        = $clog2(ARCH_REGS);
  localparam int FLIST_SIZE   = 32;
  localparam int RNID_SIZE    = ARCH_REGS + DISP_SIZE * FLIST_SIZE;
  localparam int RNID_W       = $clog2(RNID_SIZE);
  localparam int TGT_BUS_SIZE = 2;

  typedef struct packed {
    logic             valid;
    logic             rd_valid;
    logic [REG_W-1:0] rd_regidx;
    logic             rs1_valid;
    logic [REG_W-1:0] rs1_regidx;
    logic             rs2_valid;
    logic [REG_W-1:0] rs2_regidx;
    logic [31:0]      inst;        // raw instruction word
  } disp_inst_t;

  typedef struct packed {
    logic                        valid;
    logic                        is_br_included;
    logic [31:0]                 pc_addr;
    disp_inst_t [DISP_SIZE-1:0]  inst;
  } disp_group_t;

  typedef struct packed {
    disp_inst_t        disp;       // fields as dispatched
    logic [RNID_W-1:0] rd_rnid;
    logic [RNID_W-1:0] rd_old_rnid;
    logic [RNID_W-1:0] rs1_rnid;
    logic              rs1_ready;
    logic [RNID_W-1:0] rs2_rnid;
    logic              rs2_ready;
  } renamed_inst_t;

  typedef struct packed {
    logic                          valid;
    logic                          is_br_included;
    logic [31:0]                   pc_addr;
    renamed_inst_t [DISP_SIZE-1:0] inst;
  } renamed_group_t;

  // commit side, one entry per lane
  typedef struct packed {
    logic                              commit;
    logic                              is_br_included;
    logic                              mispredict;
    logic [DISP_SIZE-1:0]              rnid_valid;
    logic [DISP_SIZE-1:0]              dead;
    logic [DISP_SIZE-1:0][REG_W-1:0]   rd_regidx;
    logic [DISP_SIZE-1:0][RNID_W-1:0]  rd_rnid;
    logic [DISP_SIZE-1:0][RNID_W-1:0]  old_rnid;
  } cmt_upd_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rd_rnid;
  } phy_wr_t;

  // whole map, indexed by arch register
  typedef logic [ARCH_REGS-1:0][RNID_W-1:0] rn_list_t;

endpackage

// ==== rename_freelist.sv ====
`timescale 1ns/1ps

module rename_freelist #(
  parameter int SIZE  = 32,
  parameter int WIDTH = 7,
  parameter int INIT  = 32
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_push_id,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_pop_id
);

  localparam int PTR_W = (SIZE > 1) ? $clog2(SIZE) : 1;

  logic [WIDTH-1:0] r_list [SIZE];
  logic [PTR_W-1:0] r_head;
  logic [PTR_W-1:0] r_tail;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(SIZE - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // list starts full, so head and tail both sit at entry 0
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_tail <= '0;
      for (int i = 0; i < SIZE; i++) begin
        r_list[i] <= WIDTH'(INIT + i);
      end
    end else begin
      if (i_pop) r_head <= ptr_inc(r_head);
      if (i_push) begin
        r_list[r_tail] <= i_push_id;   // freed id goes to the back
        r_tail         <= ptr_inc(r_tail);
      end
    end
  end

  assign o_pop_id = r_list[r_head];

endmodule

// ==== rename_map.sv ====
`timescale 1ns/1ps

module rename_map (
  input  logic                                                          i_clk,
  input  logic                                                          i_reset_n,
  // source lookups, two per lane
  input  logic [2*rename_pkg::DISP_SIZE-1:0][rename_pkg::REG_W-1:0]     i_arch_id,
  output logic [2*rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0]    o_rnid,
  // destination lookup for the old rnid
  input  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::REG_W-1:0]       i_rd_regidx,
  output logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0]      o_rd_old_rnid,
  // group writes
  input  logic [rename_pkg::DISP_SIZE-1:0]                              i_update,
  input  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::REG_W-1:0]       i_update_arch_id,
  input  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0]      i_update_rnid,
  // branch recovery
  input  logic                                                          i_restore,
  input  rename_pkg::rn_list_t                                          i_restore_rn_list,
  output rename_pkg::rn_list_t                                          o_rn_list
);

  import rename_pkg::*;

  rn_list_t r_map;
  rn_list_t w_map_next;

  // lookups see the map as it stood before this group
  for (genvar s = 0; s < 2 * DISP_SIZE; s++) begin : g_src
    assign o_rnid[s] = r_map[i_arch_id[s]];
  end

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_rd
    assign o_rd_old_rnid[d] = r_map[i_rd_regidx[d]];
  end

  // later lane overwrites an earlier one on the same register
  always_comb begin
    o_rn_list = r_map;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (i_update[d]) begin
        o_rn_list[i_update_arch_id[d]] = i_update_rnid[d];
      end
    end
  end

  assign w_map_next = i_restore ? i_restore_rn_list : o_rn_list;  // restore beats updates

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        r_map[i] <= RNID_W'(i);    // identity
      end
    end else begin
      r_map <= w_map_next;
    end
  end

endmodule

// ==== rename_inflight.sv ====
`timescale 1ns/1ps

module rename_inflight (
  input  logic                                                        i_clk,
  input  logic                                                        i_reset_n,
  input  logic [2*rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0]  i_rnid,
  output logic [2*rename_pkg::DISP_SIZE-1:0]                          o_ready,
  input  logic [rename_pkg::DISP_SIZE-1:0]                            i_set_valid,
  input  logic [rename_pkg::DISP_SIZE-1:0][rename_pkg::RNID_W-1:0]    i_set_rnid,
  input  rename_pkg::phy_wr_t [rename_pkg::TGT_BUS_SIZE-1:0]          i_phy_wr
);

  import rename_pkg::*;

  logic [RNID_SIZE-1:0] r_pending;

  // registered view, so a writeback helps only from the next group on
  for (genvar s = 0; s < 2 * DISP_SIZE; s++) begin : g_rd
    assign o_ready[s] = (i_rnid[s] == '0) | ~r_pending[i_rnid[s]];
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pending <= '0;
    end else begin
      for (int w = 0; w < TGT_BUS_SIZE; w++) begin
        if (i_phy_wr[w].valid) r_pending[i_phy_wr[w].rd_rnid] <= 1'b0;
      end
      // new allocation wins over a stale writeback
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_set_valid[d]) r_pending[i_set_rnid[d]] <= 1'b1;
      end
    end
  end

endmodule

// ==== rename_map_queue.sv ====
`timescale 1ns/1ps

module rename_map_queue #(
  parameter int DEPTH = 4
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_load,
  input  rename_pkg::rn_list_t i_rn_list,
  input  logic                 i_pop,
  output rename_pkg::rn_list_t o_rn_list
);

  import rename_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  rn_list_t         r_entry [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // snapshot storage
  always_ff @(posedge i_clk) begin
    if (i_load) r_entry[r_wr_ptr] <= i_rn_list;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (i_load) r_wr_ptr <= ptr_inc(r_wr_ptr);
      if (i_pop)  r_rd_ptr <= ptr_inc(r_rd_ptr);  // oldest branch resolved
    end
  end

  assign o_rn_list = r_entry[r_rd_ptr];

endmodule

// ==== rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage #(
  parameter int MAP_Q_DEPTH = 4
) (
  input  logic                                              i_clk,
  input  logic                                              i_reset_n,
  input  rename_pkg::disp_group_t                           i_iq_disp,
  input  rename_pkg::cmt_upd_t                              i_commit,
  input  rename_pkg::phy_wr_t [rename_pkg::TGT_BUS_SIZE-1:0] i_phy_wr,
  output rename_pkg::renamed_group_t                        o_sc_disp
);

  import rename_pkg::*;

  logic [DISP_SIZE-1:0]               w_rd_wr;        // lane allocates a new rnid
  logic [DISP_SIZE-1:0][RNID_W-1:0]   w_rd_rnid;
  logic [DISP_SIZE-1:0][RNID_W-1:0]   w_rd_old_rnid;  // from the map, unforwarded
  logic [DISP_SIZE-1:0][REG_W-1:0]    w_rd_regidx;
  logic [2*DISP_SIZE-1:0][REG_W-1:0]  w_src_regidx;
  logic [2*DISP_SIZE-1:0][RNID_W-1:0] w_src_rnid;
  logic [2*DISP_SIZE-1:0]             w_src_ready;
  logic                               w_restore;
  rn_list_t                           w_rn_list;
  rn_list_t                           w_restore_rn_list;
  renamed_group_t                     w_sc_disp;

  assign w_restore = i_commit.commit & i_commit.is_br_included & i_commit.mispredict;

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    logic              w_push;
    logic [RNID_W-1:0] w_push_id;
    logic [RNID_W-1:0] w_pop_id;

    assign w_rd_wr[d] = i_iq_disp.valid & i_iq_disp.inst[d].valid &
                        i_iq_disp.inst[d].rd_valid & (i_iq_disp.inst[d].rd_regidx != '0);

    // a killed result hands back its own rnid, a retired one the previous mapping
    assign w_push    = i_commit.commit & i_commit.rnid_valid[d] &
                       (i_commit.rd_regidx[d] != '0);
    assign w_push_id = (i_commit.dead[d] | i_commit.mispredict) ? i_commit.rd_rnid[d] :
                                                                  i_commit.old_rnid[d];

    rename_freelist #(
      .SIZE  (FLIST_SIZE),
      .WIDTH (RNID_W),
      .INIT  (ARCH_REGS + FLIST_SIZE * d)
    ) u_freelist (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_push    (w_push),
      .i_push_id (w_push_id),
      .i_pop     (w_rd_wr[d]),
      .o_pop_id  (w_pop_id)
    );

    assign w_rd_rnid[d]          = w_rd_wr[d] ? w_pop_id : '0;  // x0 keeps rnid 0
    assign w_rd_regidx[d]        = i_iq_disp.inst[d].rd_regidx;
    assign w_src_regidx[2*d]     = i_iq_disp.inst[d].rs1_regidx;
    assign w_src_regidx[2*d + 1] = i_iq_disp.inst[d].rs2_regidx;
  end

  // in-group forwarding, nearest earlier writer wins
  always_comb begin
    logic rs1_fwd;
    logic rs2_fwd;

    w_sc_disp.valid          = i_iq_disp.valid;
    w_sc_disp.is_br_included = i_iq_disp.is_br_included;
    w_sc_disp.pc_addr        = i_iq_disp.pc_addr;
    for (int d = 0; d < DISP_SIZE; d++) begin
      rs1_fwd = 1'b0;
      rs2_fwd = 1'b0;
      w_sc_disp.inst[d].disp        = i_iq_disp.inst[d];
      w_sc_disp.inst[d].rd_rnid     = w_rd_rnid[d];
      w_sc_disp.inst[d].rd_old_rnid = w_rd_old_rnid[d];
      w_sc_disp.inst[d].rs1_rnid    = w_src_rnid[2*d];
      w_sc_disp.inst[d].rs2_rnid    = w_src_rnid[2*d + 1];
      for (int p = 0; p < d; p++) begin
        if (w_rd_wr[p] && w_rd_regidx[p] == i_iq_disp.inst[d].rs1_regidx) begin
          rs1_fwd                    = 1'b1;
          w_sc_disp.inst[d].rs1_rnid = w_rd_rnid[p];
        end
        if (w_rd_wr[p] && w_rd_regidx[p] == i_iq_disp.inst[d].rs2_regidx) begin
          rs2_fwd                    = 1'b1;
          w_sc_disp.inst[d].rs2_rnid = w_rd_rnid[p];
        end
        if (w_rd_wr[p] && w_rd_regidx[p] == w_rd_regidx[d]) begin
          w_sc_disp.inst[d].rd_old_rnid = w_rd_rnid[p];
        end
      end
      // producer sits in the same group, so never ready yet
      w_sc_disp.inst[d].rs1_ready = w_src_ready[2*d] & ~rs1_fwd;
      w_sc_disp.inst[d].rs2_ready = w_src_ready[2*d + 1] & ~rs2_fwd;
    end
  end

  rename_map u_map (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_arch_id         (w_src_regidx),
    .o_rnid            (w_src_rnid),
    .i_rd_regidx       (w_rd_regidx),
    .o_rd_old_rnid     (w_rd_old_rnid),
    .i_update          (w_rd_wr),
    .i_update_arch_id  (w_rd_regidx),
    .i_update_rnid     (w_rd_rnid),
    .i_restore         (w_restore),
    .i_restore_rn_list (w_restore_rn_list),
    .o_rn_list         (w_rn_list)
  );

  rename_inflight u_inflight (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_rnid      (w_src_rnid),
    .o_ready     (w_src_ready),
    .i_set_valid (w_rd_wr),
    .i_set_rnid  (w_rd_rnid),
    .i_phy_wr    (i_phy_wr)
  );

  // one snapshot per branch group, taken with the group's own writes in
  rename_map_queue #(
    .DEPTH (MAP_Q_DEPTH)
  ) u_map_queue (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_load    (i_iq_disp.valid & i_iq_disp.is_br_included),
    .i_rn_list (w_rn_list),
    .i_pop     (i_commit.commit & i_commit.is_br_included),
    .o_rn_list (w_restore_rn_list)
  );

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_sc_disp <= '0;
    end else begin
      o_sc_disp <= w_sc_disp;
    end
  end

endmodule

// ==== rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb;

  import rename_pkg::*;

  localparam int N_DIR  = 6;
  localparam int N_RAND = 300;
  localparam int N_ROWS = N_DIR + N_RAND;
  localparam int Q_DEPTH = 4;

  typedef struct packed {
    disp_group_t                 disp;
    cmt_upd_t                    cmt;
    phy_wr_t [TGT_BUS_SIZE-1:0]  wr;
    renamed_group_t              exp;
  } row_t;

  logic                       i_clk;
  logic                       i_reset_n;
  disp_group_t                i_iq_disp;
  cmt_upd_t                   i_commit;
  phy_wr_t [TGT_BUS_SIZE-1:0] i_phy_wr;
  renamed_group_t             o_sc_disp;

  row_t tbl [N_ROWS];

  // reference model state
  rn_list_t          m_map;
  rn_list_t          m_snap [$];
  cmt_upd_t          m_rob [$];   // groups waiting to retire
  logic [RNID_W-1:0] m_fl [DISP_SIZE][FLIST_SIZE];
  int                m_head [DISP_SIZE];
  int                m_tail [DISP_SIZE];
  bit                m_pend [RNID_SIZE];

  rename_stage #(.MAP_Q_DEPTH(Q_DEPTH)) rename_stage_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_iq_disp (i_iq_disp),
    .i_commit  (i_commit),
    .i_phy_wr  (i_phy_wr),
    .o_sc_disp (o_sc_disp)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic disp_inst_t make_inst(input bit v, input int rd, input int rs1,
                                           input int rs2);
    disp_inst_t di;
    di            = '0;
    di.valid      = v;
    di.rd_valid   = v;
    di.rd_regidx  = REG_W'(rd);
    di.rs1_valid  = v;
    di.rs1_regidx = REG_W'(rs1);
    di.rs2_valid  = v;
    di.rs2_regidx = REG_W'(rs2);
    di.inst       = 32'h0000_0033;  // plain add
    return di;
  endfunction

  function automatic renamed_inst_t expect_inst(input disp_inst_t di, input int rd,
                                                input int old, input int r1, input bit y1,
                                                input int r2, input bit y2);
    renamed_inst_t ri;
    ri             = '0;
    ri.disp        = di;
    ri.rd_rnid     = RNID_W'(rd);
    ri.rd_old_rnid = RNID_W'(old);
    ri.rs1_rnid    = RNID_W'(r1);
    ri.rs1_ready   = y1;
    ri.rs2_rnid    = RNID_W'(r2);
    ri.rs2_ready   = y2;
    return ri;
  endfunction

  task automatic set_group(input int k, input logic [31:0] pc, input bit br,
                           input disp_inst_t i0, input disp_inst_t i1);
    tbl[k]                         = '0;
    tbl[k].disp.valid              = 1'b1;
    tbl[k].disp.is_br_included     = br;
    tbl[k].disp.pc_addr            = pc;
    tbl[k].disp.inst[0]            = i0;
    tbl[k].disp.inst[1]            = i1;
    tbl[k].exp.valid               = 1'b1;
    tbl[k].exp.is_br_included      = br;
    tbl[k].exp.pc_addr             = pc;
    tbl[k].exp.inst[0].disp        = i0;
    tbl[k].exp.inst[1].disp        = i1;
  endtask

  // random row; commit is the oldest group still in flight
  task automatic random_row(input int k);
    disp_inst_t di [DISP_SIZE];
    bit         br;
    for (int d = 0; d < DISP_SIZE; d++) begin
      di[d] = make_inst($urandom_range(0, 9) != 0, $urandom_range(0, 15),
                        $urandom_range(0, 15), $urandom_range(0, 15));
      di[d].rd_valid  = di[d].valid & ($urandom_range(0, 4) != 0);
      di[d].rs1_valid = di[d].valid & ($urandom_range(0, 3) != 0);
      di[d].rs2_valid = di[d].valid & ($urandom_range(0, 3) != 0);
      di[d].inst      = $urandom;
    end
    br = ($urandom_range(0, 3) == 0) && (m_snap.size() < Q_DEPTH);
    set_group(k, 32'h2000 + 4 * k, br, di[0], di[1]);
    if (m_rob.size() >= 12 || (m_rob.size() > 0 && $urandom_range(0, 1) == 1)) begin
      tbl[k].cmt = m_rob.pop_front();
    end
    for (int w = 0; w < TGT_BUS_SIZE; w++) begin
      tbl[k].wr[w].valid   = ($urandom_range(0, 1) == 1);
      tbl[k].wr[w].rd_rnid = RNID_W'($urandom_range(32, RNID_SIZE - 1));
    end
  endtask

  // one clock edge of the rename rules
  task automatic model_step(input int k, input bit fill);
    disp_group_t    g;
    cmt_upd_t       c;
    cmt_upd_t       r;
    renamed_group_t e;
    rn_list_t       nxt;
    rn_list_t       snap;
    bit             wr [DISP_SIZE];
    logic [REG_W-1:0] rd;
    g   = tbl[k].disp;
    c   = tbl[k].cmt;
    e   = tbl[k].exp;
    nxt = m_map;
    for (int d = 0; d < DISP_SIZE; d++) begin
      rd    = g.inst[d].rd_regidx;
      wr[d] = g.valid && g.inst[d].valid && g.inst[d].rd_valid && rd != 0;
      e.inst[d].disp        = g.inst[d];
      e.inst[d].rd_rnid     = wr[d] ? m_fl[d][m_head[d]] : '0;
      e.inst[d].rd_old_rnid = m_map[rd];
      e.inst[d].rs1_rnid    = m_map[g.inst[d].rs1_regidx];
      e.inst[d].rs2_rnid    = m_map[g.inst[d].rs2_regidx];
      e.inst[d].rs1_ready   = (e.inst[d].rs1_rnid == 0) || !m_pend[e.inst[d].rs1_rnid];
      e.inst[d].rs2_ready   = (e.inst[d].rs2_rnid == 0) || !m_pend[e.inst[d].rs2_rnid];
      for (int p = 0; p < d; p++) begin
        if (wr[p] && g.inst[p].rd_regidx == g.inst[d].rs1_regidx) begin
          e.inst[d].rs1_rnid  = e.inst[p].rd_rnid;
          e.inst[d].rs1_ready = 1'b0;
        end
        if (wr[p] && g.inst[p].rd_regidx == g.inst[d].rs2_regidx) begin
          e.inst[d].rs2_rnid  = e.inst[p].rd_rnid;
          e.inst[d].rs2_ready = 1'b0;
        end
        if (wr[p] && g.inst[p].rd_regidx == rd) e.inst[d].rd_old_rnid = e.inst[p].rd_rnid;
      end
      if (wr[d]) begin
        nxt[rd]   = e.inst[d].rd_rnid;
        m_head[d] = (m_head[d] + 1) % FLIST_SIZE;
      end
    end
    for (int w = 0; w < TGT_BUS_SIZE; w++) begin
      if (tbl[k].wr[w].valid) m_pend[tbl[k].wr[w].rd_rnid] = 1'b0;
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (wr[d]) m_pend[e.inst[d].rd_rnid] = 1'b1;  // allocation beats writeback
    end
    snap = nxt;
    if (c.commit) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (c.rnid_valid[d] && c.rd_regidx[d] != 0) begin
          m_fl[d][m_tail[d]] = (c.dead[d] || c.mispredict) ? c.rd_rnid[d] : c.old_rnid[d];
          m_tail[d]          = (m_tail[d] + 1) % FLIST_SIZE;
        end
      end
      if (c.is_br_included) snap = m_snap.pop_front();
    end
    if (g.valid && g.is_br_included) m_snap.push_back(nxt);
    m_map = (c.commit && c.is_br_included && c.mispredict) ? snap : nxt;
    if (fill) begin
      tbl[k].exp = e;
      r                = '0;
      r.commit         = 1'b1;
      r.is_br_included = g.is_br_included;
      r.mispredict     = g.is_br_included && ($urandom_range(0, 3) == 0);
      for (int d = 0; d < DISP_SIZE; d++) begin
        r.rnid_valid[d] = wr[d];
        r.dead[d]       = ($urandom_range(0, 7) == 0);
        r.rd_regidx[d]  = g.inst[d].rd_regidx;
        r.rd_rnid[d]    = e.inst[d].rd_rnid;
        r.old_rnid[d]   = e.inst[d].rd_old_rnid;
      end
      m_rob.push_back(r);
    end
  endtask

  task automatic build_table();
    for (int i = 0; i < ARCH_REGS; i++) m_map[i] = RNID_W'(i);
    for (int d = 0; d < DISP_SIZE; d++) begin
      m_head[d] = 0;
      m_tail[d] = 0;
      for (int i = 0; i < FLIST_SIZE; i++) m_fl[d][i] = RNID_W'(ARCH_REGS + FLIST_SIZE * d + i);
    end
    for (int i = 0; i < RNID_SIZE; i++) m_pend[i] = 1'b0;
    // identity map, first ids of each lane, forwarding
    set_group(0, 32'h1000, 1'b0, make_inst(1, 1, 2, 3), make_inst(1, 4, 1, 5));
    tbl[0].exp.inst[0] = expect_inst(tbl[0].disp.inst[0], 32, 1, 2, 1, 3, 1);
    tbl[0].exp.inst[1] = expect_inst(tbl[0].disp.inst[1], 64, 4, 32, 0, 5, 1);
    set_group(1, 32'h1004, 1'b0, make_inst(1, 1, 4, 0), make_inst(1, 1, 1, 6));
    tbl[1].wr[0].valid   = 1'b1;
    tbl[1].wr[0].rd_rnid = 64;   // written on this edge so still pending here
    tbl[1].exp.inst[0] = expect_inst(tbl[1].disp.inst[0], 33, 32, 64, 0, 0, 1);
    tbl[1].exp.inst[1] = expect_inst(tbl[1].disp.inst[1], 65, 33, 33, 0, 6, 1);
    set_group(2, 32'h1008, 1'b1, make_inst(1, 7, 1, 4), make_inst(1, 0, 7, 2));
    tbl[2].exp.inst[0] = expect_inst(tbl[2].disp.inst[0], 34, 7, 65, 0, 64, 1);
    tbl[2].exp.inst[1] = expect_inst(tbl[2].disp.inst[1], 0, 0, 34, 0, 2, 1);
    set_group(3, 32'h100c, 1'b0, make_inst(1, 7, 1, 1), make_inst(1, 1, 7, 4));
    tbl[3].exp.inst[0] = expect_inst(tbl[3].disp.inst[0], 35, 34, 65, 0, 65, 0);
    tbl[3].exp.inst[1] = expect_inst(tbl[3].disp.inst[1], 66, 65, 35, 0, 64, 1);
    // mispredict of the branch group restores the row 2 snapshot
    set_group(4, 32'h1010, 1'b0, make_inst(1, 9, 7, 1), make_inst(0, 0, 0, 0));
    tbl[4].cmt.commit         = 1'b1;
    tbl[4].cmt.is_br_included = 1'b1;
    tbl[4].cmt.mispredict     = 1'b1;
    tbl[4].exp.inst[0] = expect_inst(tbl[4].disp.inst[0], 36, 9, 35, 0, 66, 0);
    set_group(5, 32'h1014, 1'b0, make_inst(1, 10, 7, 1), make_inst(1, 11, 4, 9));
    tbl[5].exp.inst[0] = expect_inst(tbl[5].disp.inst[0], 37, 10, 34, 0, 65, 0);
    tbl[5].exp.inst[1] = expect_inst(tbl[5].disp.inst[1], 67, 11, 64, 1, 9, 1);
    for (int k = 0; k < N_DIR; k++) model_step(k, 1'b0);
    for (int k = N_DIR; k < N_ROWS; k++) begin
      random_row(k);
      model_step(k, 1'b1);
    end
  endtask

  task automatic apply_row(input int k);
    i_iq_disp <= tbl[k].disp;
    i_commit  <= tbl[k].cmt;
    i_phy_wr  <= tbl[k].wr;
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got == exp) else begin
      $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic wait_valid();
    int cnt;
    cnt = 0;
    do begin
      @(negedge i_clk);
      cnt++;
    end while (!o_sc_disp.valid && cnt < 10);
    if (!o_sc_disp.valid) begin
      $display("timed out waiting for o_sc_disp.valid at %0t ns", $time);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  endtask

  task automatic check_row(input int k);
    renamed_inst_t e;
    check_field("o_sc_disp.pc_addr", o_sc_disp.pc_addr, tbl[k].exp.pc_addr);
    check_field("o_sc_disp.is_br_included", o_sc_disp.is_br_included,
                tbl[k].exp.is_br_included);
    for (int d = 0; d < DISP_SIZE; d++) begin
      e = tbl[k].exp.inst[d];
      check_field($sformatf("o_sc_disp.inst[%0d].disp", d), o_sc_disp.inst[d].disp, e.disp);
      if (e.disp.valid) begin
        check_field($sformatf("o_sc_disp.inst[%0d].rd_rnid", d),
                    o_sc_disp.inst[d].rd_rnid, e.rd_rnid);
        if (e.disp.rd_valid) check_field($sformatf("o_sc_disp.inst[%0d].rd_old_rnid", d),
                                         o_sc_disp.inst[d].rd_old_rnid, e.rd_old_rnid);
        if (e.disp.rs1_valid) begin
          check_field($sformatf("o_sc_disp.inst[%0d].rs1_rnid", d),
                      o_sc_disp.inst[d].rs1_rnid, e.rs1_rnid);
          check_field($sformatf("o_sc_disp.inst[%0d].rs1_ready", d),
                      o_sc_disp.inst[d].rs1_ready, e.rs1_ready);
        end
        if (e.disp.rs2_valid) begin
          check_field($sformatf("o_sc_disp.inst[%0d].rs2_rnid", d),
                      o_sc_disp.inst[d].rs2_rnid, e.rs2_rnid);
          check_field($sformatf("o_sc_disp.inst[%0d].rs2_ready", d),
                      o_sc_disp.inst[d].rs2_ready, e.rs2_ready);
        end
      end
    end
  endtask

  initial begin
    void'($urandom(81));
    i_reset_n = 1'b0;
    i_iq_disp = '0;
    i_commit  = '0;
    i_phy_wr  = '0;
    build_table();
    repeat (3) @(posedge i_clk);
    check_field("o_sc_disp.valid", o_sc_disp.valid, 0);  // output idle in reset
    i_reset_n <= 1'b1;
    @(posedge i_clk);
    apply_row(0);
    for (int k = 0; k < N_ROWS; k++) begin
      @(posedge i_clk);
      if (k + 1 < N_ROWS) begin
        apply_row(k + 1);
      end else begin
        i_iq_disp <= '0;
        i_commit  <= '0;
        i_phy_wr  <= '0;
      end
      wait_valid();   // row k is on the output now
      check_row(k);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== rename.f ====
rename_pkg.sv
rename_freelist.sv
rename_map.sv
rename_inflight.sv
rename_map_queue.sv
rename_stage.sv
rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename

sources:
  - rename_pkg.sv
  - rename_freelist.sv
  - rename_map.sv
  - rename_inflight.sv
  - rename_map_queue.sv
  - rename_stage.sv
  - target: test
    files:
      - rename_tb.sv
